/* build.f */
source/hsid_pkg.sv
source/hsid_fifo.sv
source/hsid_spectral_regs.sv
source/hsid_distance_engine.sv
source/hsid_anomaly_top.sv
verification/hsid_result_checker.sv
verification/hsid_anomaly_tb.sv

/* source/hsid_anomaly_top.sv */
`default_nettype none

module hsid_anomaly_top
  import hsid_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      sample_valid,
  input  wire logic [SAMPLE_WIDTH-1:0]   sample_data,
  input  wire logic                      cfg_wr,
  input  wire logic [CFG_ADDR_WIDTH-1:0] cfg_addr,
  input  wire logic [SAMPLE_WIDTH-1:0]   cfg_wdata,
  output logic                           result_valid,
  output logic      [SAD_WIDTH-1:0]      result_distance,
  output logic                           result_anomaly,
  output logic                           fifo_full,
  output logic                           fifo_almost_full
);

  // FIFO to engine
  logic                    fifo_rd_en;     // Engine pop request
  logic [SAMPLE_WIDTH-1:0] fifo_data_out;  // Popped sample
  logic                    fifo_rd_valid;  // Popped sample is valid

  // Registers to engine
  logic [NUM_BANDS*SAMPLE_WIDTH-1:0] ref_spectrum;
  logic [SAMPLE_WIDTH-1:0]           threshold;
  logic                              enable;

  // Sample buffer, drops input while full
  hsid_fifo #(
    .DATA_WIDTH            (SAMPLE_WIDTH),
    .FIFO_DEPTH            (FIFO_DEPTH),
    .ALMOST_FULL_THRESHOLD (FIFO_ALMOST_FULL_LEVEL)
  ) hsid_fifo_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_en       (sample_valid),
    .rd_en       (fifo_rd_en),
    .data_in     (sample_data),
    .data_out    (fifo_data_out),
    .rd_valid    (fifo_rd_valid),
    .full        (fifo_full),
    .almost_full (fifo_almost_full),
    .empty       ()                  // Engine never looks at empty
  );

  // Reference spectrum, threshold and enable
  hsid_spectral_regs hsid_spectral_regs_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_wr       (cfg_wr),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .ref_spectrum (ref_spectrum),
    .threshold    (threshold),
    .enable       (enable)
  );

  // Per-pixel SAD and anomaly decision
  hsid_distance_engine hsid_distance_engine_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable          (enable),
    .sample_valid    (fifo_rd_valid),
    .sample_data     (fifo_data_out),
    .ref_spectrum    (ref_spectrum),
    .threshold       (threshold),
    .pop             (fifo_rd_en),
    .result_valid    (result_valid),
    .result_distance (result_distance),
    .result_anomaly  (result_anomaly)
  );

endmodule

`default_nettype wire

/* source/hsid_distance_engine.sv */
`default_nettype none

module hsid_distance_engine
  import hsid_pkg::*;
(
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  input  wire logic                              enable,
  input  wire logic                              sample_valid,  // FIFO rd_valid
  input  wire logic [SAMPLE_WIDTH-1:0]           sample_data,
  input  wire logic [NUM_BANDS*SAMPLE_WIDTH-1:0] ref_spectrum,
  input  wire logic [SAMPLE_WIDTH-1:0]           threshold,
  output logic                                   pop,
  output logic                                   result_valid,
  output logic      [SAD_WIDTH-1:0]              result_distance,
  output logic                                   result_anomaly
);

  localparam logic [BAND_IDX_WIDTH-1:0] LAST_BAND = BAND_IDX_WIDTH'(NUM_BANDS - 1);

  logic [BAND_IDX_WIDTH-1:0] band_cnt;   // Band of the next sample
  logic [SAD_WIDTH-1:0]      acc;        // Partial SAD of current pixel

  logic [SAMPLE_WIDTH-1:0]   ref_sel;    // Reference for this band
  logic [SAMPLE_WIDTH-1:0]   abs_diff;   // |sample - ref|
  logic [SAD_WIDTH-1:0]      sum_next;   // Accumulator plus this band
  logic [SAD_WIDTH-1:0]      thresh_ext; // Threshold at SAD width
  logic                      last_band;  // Sample closes a pixel

  // FIFO gates the pop on empty itself
  assign pop = enable;

  assign ref_sel = ref_spectrum[band_cnt*SAMPLE_WIDTH +: SAMPLE_WIDTH];

  // Subtract in the order that stays non-negative
  assign abs_diff = (sample_data >= ref_sel) ? (sample_data - ref_sel)
                                             : (ref_sel - sample_data);

  assign sum_next   = acc + SAD_WIDTH'(abs_diff);
  assign thresh_ext = {{(SAD_WIDTH - SAMPLE_WIDTH){1'b0}}, threshold};
  assign last_band  = (band_cnt == LAST_BAND);

  // Band counter and accumulator
  // Samples in flight are absorbed even after enable drops
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      band_cnt <= '0;
      acc      <= '0;
    end else if (sample_valid) begin
      if (last_band) begin
        band_cnt <= '0;  // Next pixel starts at band 0
        acc      <= '0;  // Clean sum for next pixel
      end else begin
        band_cnt <= band_cnt + 1'b1;
        acc      <= sum_next;
      end
    end
  end

  // One-cycle result strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= sample_valid && last_band;
    end
  end

  // Result payload, held until the next pixel closes
  always_ff @(posedge clk) begin
    if (sample_valid && last_band) begin
      result_distance <= sum_next;
      result_anomaly  <= (sum_next > thresh_ext);  // Strictly above threshold
    end
  end

endmodule

`default_nettype wire

/* source/hsid_fifo.sv */
`default_nettype none

module hsid_fifo
  import hsid_pkg::*;
#(
  parameter int DATA_WIDTH            = SAMPLE_WIDTH,            // Entry width
  parameter int FIFO_DEPTH            = hsid_pkg::FIFO_DEPTH,    // Number of entries
  parameter int ALMOST_FULL_THRESHOLD = FIFO_ALMOST_FULL_LEVEL   // Count for almost full
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  wr_en,
  input  wire logic                  rd_en,
  input  wire logic [DATA_WIDTH-1:0] data_in,
  output logic      [DATA_WIDTH-1:0] data_out,
  output logic                       rd_valid,
  output logic                       full,
  output logic                       almost_full,
  output logic                       empty
);

  // A single-entry FIFO still needs a one-bit pointer
  localparam int ADDR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(FIFO_DEPTH - 1);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];  // Sample storage

  logic [ADDR_WIDTH-1:0] wr_ptr;  // Next slot to write
  logic [ADDR_WIDTH-1:0] rd_ptr;  // Next slot to read
  logic [ADDR_WIDTH:0]   count;   // Occupancy, reaches FIFO_DEPTH

  logic do_write;  // Accepted write this cycle
  logic do_read;   // Pop this cycle

  // Flags straight from the count
  assign full        = (count == (ADDR_WIDTH + 1)'(FIFO_DEPTH));
  assign almost_full = (count >= (ADDR_WIDTH + 1)'(ALMOST_FULL_THRESHOLD));
  assign empty       = (count == '0);

  assign do_write = wr_en && !full;   // Drop when full
  assign do_read  = rd_en && !empty;  // FIFO owns the empty test

  // Occupancy tracking
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({do_read, do_write})
        2'b01:   count <= count + 1'b1;  // Write only
        2'b10:   count <= count - 1'b1;  // Read only
        default: count <= count;         // Idle or both
      endcase
    end
  end

  // Pointers wrap at depth, not at a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == LAST_ADDR) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // Storage write
  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= data_in;
    end
  end

  // Registered read port, only moves on a pop
  always_ff @(posedge clk) begin
    if (do_read) begin
      data_out <= mem[rd_ptr];
    end
  end

  // Marks data_out as fresh for one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= do_read;
    end
  end

endmodule

`default_nettype wire

/* source/hsid_pkg.sv */
`default_nettype none

package hsid_pkg;

  // Sample path
  localparam int SAMPLE_WIDTH   = 16;  // One band sample
  localparam int NUM_BANDS      = 8;   // Bands per pixel
  localparam int BAND_IDX_WIDTH = 3;   // Holds 0 .. NUM_BANDS-1

  // Eight full-scale differences need three extra bits
  localparam int SAD_WIDTH = 19;

  // Sample FIFO sizing
  localparam int FIFO_DEPTH             = 8;
  localparam int FIFO_ALMOST_FULL_LEVEL = 7;  // Count where almost full rises

  // Configuration bus
  localparam int CFG_ADDR_WIDTH = 4;

  // Register map, 10 to 15 unmapped
  typedef enum logic [CFG_ADDR_WIDTH-1:0] {
    REG_REF_0     = 4'd0,
    REG_REF_1     = 4'd1,
    REG_REF_2     = 4'd2,
    REG_REF_3     = 4'd3,
    REG_REF_4     = 4'd4,
    REG_REF_5     = 4'd5,
    REG_REF_6     = 4'd6,
    REG_REF_7     = 4'd7,
    REG_THRESHOLD = 4'd8,
    REG_CONTROL   = 4'd9   // Bit 0 is enable
  } cfg_reg_e;

endpackage

`default_nettype wire

/* source/hsid_spectral_regs.sv */
`default_nettype none

module hsid_spectral_regs
  import hsid_pkg::*;
(
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  input  wire logic                              cfg_wr,
  input  wire logic [CFG_ADDR_WIDTH-1:0]         cfg_addr,
  input  wire logic [SAMPLE_WIDTH-1:0]           cfg_wdata,
  output logic      [NUM_BANDS*SAMPLE_WIDTH-1:0] ref_spectrum,
  output logic      [SAMPLE_WIDTH-1:0]           threshold,
  output logic                                   enable
);

  logic [SAMPLE_WIDTH-1:0] ref_q [NUM_BANDS];  // Reference spectrum entries
  logic [SAMPLE_WIDTH-1:0] threshold_q;        // Anomaly threshold
  logic                    enable_q;           // Engine drain enable

  cfg_reg_e                  addr_e;    // Decoded address
  logic [BAND_IDX_WIDTH-1:0] ref_idx;   // Band slot for REF writes

  assign addr_e  = cfg_reg_e'(cfg_addr);
  assign ref_idx = cfg_addr[BAND_IDX_WIDTH-1:0];  // REF_0..7 map to 0..7

  // Register writes, take effect on the strobe edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_BANDS; i++) begin
        ref_q[i] <= '0;
      end
      threshold_q <= '0;
      enable_q    <= 1'b0;
    end else if (cfg_wr) begin
      case (addr_e)
        REG_REF_0,
        REG_REF_1,
        REG_REF_2,
        REG_REF_3,
        REG_REF_4,
        REG_REF_5,
        REG_REF_6,
        REG_REF_7: begin
          ref_q[ref_idx] <= cfg_wdata;  // One spectrum entry
        end
        REG_THRESHOLD: begin
          threshold_q <= cfg_wdata;
        end
        REG_CONTROL: begin
          enable_q <= cfg_wdata[0];  // Upper bits ignored
        end
        default: begin
          // Unmapped, nothing changes
        end
      endcase
    end
  end

  // Flatten entries, band 0 in the low slice
  always_comb begin
    for (int i = 0; i < NUM_BANDS; i++) begin
      ref_spectrum[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = ref_q[i];
    end
  end

  assign threshold = threshold_q;
  assign enable    = enable_q;

endmodule

`default_nettype wire

/* verification/hsid_anomaly_tb.sv */
`default_nettype none

module hsid_anomaly_tb
  import hsid_pkg::*;
();

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;  // Inputs move this long after the edge
  localparam int NUM_TESTS   = 6;
  localparam int RESULT_WAIT = 64;  // Cycles allowed for outstanding results

  typedef enum int {PATTERN_ZERO, PATTERN_RANDOM} ref_pattern_e;
  typedef enum int {EXTRA_NONE, EXTRA_THRESH_EDGE, EXTRA_MIDSTREAM} extra_e;

  logic                      clk;
  logic                      rst_n;
  logic                      sample_valid;
  logic [SAMPLE_WIDTH-1:0]   sample_data;
  logic                      cfg_wr;
  logic [CFG_ADDR_WIDTH-1:0] cfg_addr;
  logic [SAMPLE_WIDTH-1:0]   cfg_wdata;
  logic                      result_valid;
  logic [SAD_WIDTH-1:0]      result_distance;
  logic                      result_anomaly;
  logic                      fifo_full;
  logic                      fifo_almost_full;

  // Test table, one index per row
  string                   name_t    [NUM_TESTS];
  ref_pattern_e            pattern_t [NUM_TESTS];
  logic [SAMPLE_WIDTH-1:0] thresh_t  [NUM_TESTS];
  int                      pixels_t  [NUM_TESTS];  // Results expected
  bit                      paused_t  [NUM_TESTS];  // Fill FIFO before enabling
  extra_e                  extra_t   [NUM_TESTS];
  logic [SAMPLE_WIDTH-1:0] mask_t    [NUM_TESTS];  // Limits sample range

  logic [SAMPLE_WIDTH-1:0] pix_buf [NUM_BANDS];  // Pixel about to be sent
  integer seed        = 55723;
  int     pass_count  = 0;
  int     fail_count  = 0;
  bit     table_ready = 1'b0;

  hsid_anomaly_top hsid_anomaly_top_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .sample_valid     (sample_valid),
    .sample_data      (sample_data),
    .cfg_wr           (cfg_wr),
    .cfg_addr         (cfg_addr),
    .cfg_wdata        (cfg_wdata),
    .result_valid     (result_valid),
    .result_distance  (result_distance),
    .result_anomaly   (result_anomaly),
    .fifo_full        (fifo_full),
    .fifo_almost_full (fifo_almost_full)
  );

  hsid_result_checker hsid_result_checker_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .sample_valid     (sample_valid),
    .sample_data      (sample_data),
    .cfg_wr           (cfg_wr),
    .cfg_addr         (cfg_addr),
    .cfg_wdata        (cfg_wdata),
    .result_valid     (result_valid),
    .result_distance  (result_distance),
    .result_anomaly   (result_anomaly),
    .fifo_full        (fifo_full),
    .fifo_almost_full (fifo_almost_full)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic set_row(input int t, input string name, input ref_pattern_e pattern,
                         input logic [SAMPLE_WIDTH-1:0] thresh, input int pixels,
                         input bit paused, input extra_e extra,
                         input logic [SAMPLE_WIDTH-1:0] mask);
    name_t[t]    = name;
    pattern_t[t] = pattern;
    thresh_t[t]  = thresh;
    pixels_t[t]  = pixels;
    paused_t[t]  = paused;
    extra_t[t]   = extra;
    mask_t[t]    = mask;
  endtask

  task automatic load_table();
    set_row(0, "reset_idle",         PATTERN_ZERO,   16'd0,     0, 0, EXTRA_NONE, 16'hffff);
    set_row(1, "zero_reference",     PATTERN_ZERO,   16'd32768, 4, 0, EXTRA_NONE, 16'h1fff);
    set_row(2, "random_stream",      PATTERN_RANDOM, 16'd11000, 12, 0, EXTRA_NONE, 16'h0fff);
    set_row(3, "paused_fill",        PATTERN_RANDOM, 16'd30000, 1, 1, EXTRA_NONE, 16'hffff);
    set_row(4, "threshold_edge",     PATTERN_ZERO,   16'd0,     2, 0, EXTRA_THRESH_EDGE,
            16'h0fff);
    set_row(5, "unmapped_midstream", PATTERN_RANDOM, 16'd11000, 6, 0, EXTRA_MIDSTREAM,
            16'h0fff);
  endtask

  function automatic logic [SAMPLE_WIDTH-1:0] random_sample(input logic [SAMPLE_WIDTH-1:0] mask);
    logic [31:0] r;
    r = $random(seed);
    return r[SAMPLE_WIDTH-1:0] & mask;
  endfunction

  // Ends just after a rising edge, where inputs change
  task automatic tick();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic cfg_write(input logic [CFG_ADDR_WIDTH-1:0] addr,
                           input logic [SAMPLE_WIDTH-1:0] data);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    tick();
    cfg_wr    = 1'b0;
  endtask

  task automatic send_sample(input logic [SAMPLE_WIDTH-1:0] data);
    sample_valid = 1'b1;
    sample_data  = data;
    tick();
    sample_valid = 1'b0;
  endtask

  task automatic fill_pixel(input logic [SAMPLE_WIDTH-1:0] mask);
    for (int b = 0; b < NUM_BANDS; b++) begin
      pix_buf[b] = random_sample(mask);
    end
  endtask

  task automatic send_pixel();
    for (int b = 0; b < NUM_BANDS; b++) begin
      send_sample(pix_buf[b]);
    end
  endtask

  task automatic load_reference(input ref_pattern_e pattern, input logic [SAMPLE_WIDTH-1:0] mask);
    for (int b = 0; b < NUM_BANDS; b++) begin
      if (pattern == PATTERN_RANDOM) begin
        cfg_write(b[CFG_ADDR_WIDTH-1:0], random_sample(mask));
      end else begin
        cfg_write(b[CFG_ADDR_WIDTH-1:0], '0);
      end
    end
  endtask

  task automatic wait_results(input int target, inout bit ok);
    int waited;
    waited = 0;
    while (hsid_result_checker_inst.results_seen < target && waited < RESULT_WAIT) begin
      tick();
      waited++;
    end
    if (hsid_result_checker_inst.results_seen < target) begin
      $display("Missing results at %0t: %0d of %0d pixel results never arrived", $time,
               target - hsid_result_checker_inst.results_seen, target);
      ok = 1'b0;
    end
  endtask

  task automatic expect_bit(input string name, input logic expected, input logic actual,
                            inout bit ok);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s expected %0b, actual %0b", $time, name, expected, actual);
      ok = 1'b0;
    end
  endtask

  // Engine disabled and FIFO empty, nothing may move
  task automatic check_idle(inout bit ok);
    repeat (16) begin
      tick();
      expect_bit("result_valid", 1'b0, result_valid, ok);
      expect_bit("fifo_full", 1'b0, fifo_full, ok);
      expect_bit("fifo_almost_full", 1'b0, fifo_almost_full, ok);
    end
  endtask

  // Zero reference, so the distance is the plain sample sum
  task automatic run_threshold_edge(input int t, input int base, inout bit ok);
    int sad;
    sad = 0;
    fill_pixel(mask_t[t]);
    if (pix_buf[0] == '0) begin
      pix_buf[0] = 16'd1;  // Keeps threshold minus one positive
    end
    for (int b = 0; b < NUM_BANDS; b++) begin
      sad += pix_buf[b];
    end
    cfg_write(REG_THRESHOLD, sad[SAMPLE_WIDTH-1:0]);  // Distance equals threshold
    cfg_write(REG_CONTROL, 16'd1);
    send_pixel();
    wait_results(base + 1, ok);
    expect_bit("result_anomaly", 1'b0, result_anomaly, ok);
    cfg_write(REG_THRESHOLD, sad[SAMPLE_WIDTH-1:0] - 1'b1);
    send_pixel();  // Same pixel again
    wait_results(base + 2, ok);
    expect_bit("result_anomaly", 1'b1, result_anomaly, ok);
  endtask

  task automatic run_midstream(input int t, input int base, inout bit ok);
    logic [CFG_ADDR_WIDTH-1:0] unmapped;
    unmapped = 4'd10;  // First address past REG_CONTROL
    cfg_write(REG_CONTROL, 16'd1);
    for (int p = 0; p < 3; p++) begin
      fill_pixel(mask_t[t]);
      send_pixel();
      cfg_write(unmapped, 16'hffff);      // Must be ignored
      cfg_write(unmapped + 1'b1, 16'hffff);
      unmapped = unmapped + 2'd2;
    end
    wait_results(base + 3, ok);  // Pipeline drained before the new reference
    cfg_write(REG_REF_3, random_sample(mask_t[t]));
    for (int p = 0; p < 3; p++) begin
      fill_pixel(mask_t[t]);
      send_pixel();
    end
    wait_results(base + 6, ok);
  endtask

  task automatic run_test(input int t);
    int base_errors;
    int base_results;
    bit ok;
    base_errors  = hsid_result_checker_inst.error_count;
    base_results = hsid_result_checker_inst.results_seen;
    ok = 1'b1;
    cfg_write(REG_CONTROL, 16'd0);  // Engine parked during setup
    load_reference(pattern_t[t], mask_t[t]);
    cfg_write(REG_THRESHOLD, thresh_t[t]);
    if (pixels_t[t] == 0) begin
      check_idle(ok);
    end else if (paused_t[t]) begin
      for (int n = 0; n < pixels_t[t] * NUM_BANDS + 2; n++) begin
        send_sample(random_sample(mask_t[t]));  // Last two hit a full FIFO
      end
      repeat (4) tick();
      cfg_write(REG_CONTROL, 16'd1);
      wait_results(base_results + pixels_t[t], ok);
    end else if (extra_t[t] == EXTRA_THRESH_EDGE) begin
      run_threshold_edge(t, base_results, ok);
    end else if (extra_t[t] == EXTRA_MIDSTREAM) begin
      run_midstream(t, base_results, ok);
    end else begin
      cfg_write(REG_CONTROL, 16'd1);
      for (int p = 0; p < pixels_t[t]; p++) begin
        fill_pixel(mask_t[t]);
        send_pixel();  // Back to back
      end
      wait_results(base_results + pixels_t[t], ok);
    end
    repeat (8) tick();  // Catches stray results
    if (hsid_result_checker_inst.error_count != base_errors) begin
      ok = 1'b0;
    end
    if (ok) begin
      pass_count++;
    end else begin
      fail_count++;
    end
    $display("Test %0d %s: %s", t, name_t[t], ok ? "passed" : "failed");
  endtask

  // Budget grows with the samples in the table
  initial begin : watchdog
    int     total_samples;
    longint limit_cycles;
    wait (table_ready);
    total_samples = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total_samples += pixels_t[t] * NUM_BANDS + (paused_t[t] ? 2 : 0);
    end
    limit_cycles = total_samples * 4 + NUM_TESTS * (4 * RESULT_WAIT + 64);
    #(limit_cycles * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, run did not finish", limit_cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    rst_n        = 1'b0;
    sample_valid = 1'b0;
    sample_data  = '0;
    cfg_wr       = 1'b0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    load_table();
    table_ready = 1'b1;
    repeat (4) @(posedge clk);  // Reset over four cycles
    #DRIVE_DELAY;
    rst_n = 1'b1;
    tick();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Summary: %0d passed, %0d failed, %0d checker errors, %0d samples dropped",
             pass_count, fail_count, hsid_result_checker_inst.error_count,
             hsid_result_checker_inst.dropped_count);
    if (fail_count == 0 && hsid_result_checker_inst.error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/hsid_result_checker.sv */
`default_nettype none

module hsid_result_checker
  import hsid_pkg::*;
(
  input wire logic                      clk,
  input wire logic                      rst_n,
  input wire logic                      sample_valid,
  input wire logic [SAMPLE_WIDTH-1:0]   sample_data,
  input wire logic                      cfg_wr,
  input wire logic [CFG_ADDR_WIDTH-1:0] cfg_addr,
  input wire logic [SAMPLE_WIDTH-1:0]   cfg_wdata,
  input wire logic                      result_valid,
  input wire logic [SAD_WIDTH-1:0]      result_distance,
  input wire logic                      result_anomaly,
  input wire logic                      fifo_full,
  input wire logic                      fifo_almost_full
);

  logic [SAMPLE_WIDTH-1:0] ref_m [NUM_BANDS];  // Mirrored reference spectrum
  logic [SAMPLE_WIDTH-1:0] thr_m;              // Mirrored threshold
  logic                    en_m;               // Mirrored enable bit
  logic [SAMPLE_WIDTH-1:0] fifo_m [$];         // Samples sitting in the FIFO
  logic                    popped_m;           // Pop on the coming edge
  logic [SAMPLE_WIDTH-1:0] popped_data_m;      // Sample of that pop
  int                      band_m;             // Band of next absorbed sample
  int                      occ_m;              // Occupancy before the edge
  logic [SAD_WIDTH-1:0]    acc_m;              // Running SAD of current pixel
  logic [SAD_WIDTH-1:0]    exp_dist_q [$];     // Predicted distances in order
  logic                    exp_anom_q [$];     // Predicted anomaly flags

  int results_seen   = 0;  // Polled by the testbench
  int error_count    = 0;
  int dropped_count  = 0;

  task automatic clear_model();
    for (int b = 0; b < NUM_BANDS; b++) begin
      ref_m[b] = '0;
    end
    thr_m    = '0;
    en_m     = 1'b0;
    popped_m = 1'b0;
    band_m   = 0;
    acc_m    = '0;
    fifo_m.delete();
    exp_dist_q.delete();
    exp_anom_q.delete();
  endtask

  task automatic compare_flags();
    if (fifo_full !== (occ_m == FIFO_DEPTH)) begin
      $display("Mismatch at %0t: fifo_full expected %0b, actual %0b",
               $time, (occ_m == FIFO_DEPTH), fifo_full);
      error_count++;
    end
    if (fifo_almost_full !== (occ_m >= FIFO_ALMOST_FULL_LEVEL)) begin
      $display("Mismatch at %0t: fifo_almost_full expected %0b, actual %0b",
               $time, (occ_m >= FIFO_ALMOST_FULL_LEVEL), fifo_almost_full);
      error_count++;
    end
  endtask

  task automatic compare_result();
    logic [SAD_WIDTH-1:0] exp_dist;
    logic                 exp_anom;
    results_seen++;
    if (exp_dist_q.size() == 0) begin
      $display("Unexpected result at %0t: result_valid high with no pixel pending", $time);
      error_count++;
    end else begin
      exp_dist = exp_dist_q.pop_front();
      exp_anom = exp_anom_q.pop_front();
      if (result_distance !== exp_dist) begin
        $display("Mismatch at %0t: result_distance expected %0d, actual %0d",
                 $time, exp_dist, result_distance);
        error_count++;
      end
      if (result_anomaly !== exp_anom) begin
        $display("Mismatch at %0t: result_anomaly expected %0b, actual %0b",
                 $time, exp_anom, result_anomaly);
        error_count++;
      end
    end
  endtask

  // Sample popped one edge earlier meets the reference of this cycle
  task automatic absorb_sample();
    if (popped_data_m >= ref_m[band_m]) begin
      acc_m = acc_m + (popped_data_m - ref_m[band_m]);
    end else begin
      acc_m = acc_m + (ref_m[band_m] - popped_data_m);
    end
    if (band_m == NUM_BANDS - 1) begin  // Pixel complete
      exp_dist_q.push_back(acc_m);
      exp_anom_q.push_back(acc_m > thr_m);  // Strictly above
      acc_m  = '0;
      band_m = 0;
    end else begin
      band_m++;
    end
  endtask

  task automatic mirror_cfg_write();
    if (cfg_addr <= REG_REF_7) begin
      ref_m[cfg_addr[BAND_IDX_WIDTH-1:0]] = cfg_wdata;
    end else if (cfg_addr == REG_THRESHOLD) begin
      thr_m = cfg_wdata;
    end else if (cfg_addr == REG_CONTROL) begin
      en_m = cfg_wdata[0];
    end
    // 10 to 15 leave the mirror alone
  endtask

  // Each falling edge predicts what the next rising edge does
  always @(negedge clk) begin
    if (!rst_n) begin
      clear_model();
    end else begin
      occ_m = fifo_m.size();
      compare_flags();
      if (result_valid) begin
        compare_result();
      end
      if (popped_m) begin
        absorb_sample();
      end
      popped_m = en_m && (occ_m > 0);  // Pop needs enable and data
      if (popped_m) begin
        popped_data_m = fifo_m.pop_front();
      end
      if (sample_valid) begin
        if (occ_m < FIFO_DEPTH) begin
          fifo_m.push_back(sample_data);
        end else begin
          dropped_count++;  // Full FIFO drops it
        end
      end
      if (cfg_wr) begin
        mirror_cfg_write();
      end
    end
  end

endmodule

`default_nettype wire
